/* source/radio_ctrl_config.svh */
`ifndef RADIO_CTRL_CONFIG_SVH
`define RADIO_CTRL_CONFIG_SVH

// System clock in Hz
`define RC_CLK_FREQ 76800000

// Phase multiplier 2^57 / clock for the supported clocks
`define RC_PHASE_MULT ((`RC_CLK_FREQ == 61440000) ? 32'd2345624805 : \
                       (`RC_CLK_FREQ == 79872000) ? 32'd1804326773 : \
                       (`RC_CLK_FREQ == 76800000) ? 32'd1876499845 : 32'd1954687338)

// Round to nearest before the slice
`define RC_PHASE_ROUND 32'd16777216
`define RC_PHASE_MSB 56
`define RC_PHASE_LSB 25

// Command register map
`define RC_ADDR_CTRL      6'h00
`define RC_ADDR_VNA       6'h09
`define RC_ADDR_CW_HANG   6'h10
`define RC_ADDR_TX_TIMING 6'h17
`define RC_ADDR_PRED      6'h2b
`define RC_FREQ_ADDR_TX0  6'h01
`define RC_FREQ_ADDR_RX0  6'h02

// Drive levels
`define RC_MAX_CWLEVEL 19'h4d800
`define RC_VNA_DRIVE   16'h4d80

// Timing register defaults in ms
`define RC_LATENCY_RST  5'd10
`define RC_PTT_HANG_RST 5'd4

`endif

/* source/radio_ctrl_pkg.sv */
`default_nettype none

package radio_ctrl_pkg;

  typedef logic [31:0] phase_t;
  typedef logic signed [15:0] iq_sample_t;
  typedef logic [6:0] qtimer_t;
  typedef logic [18:0] cw_level_t;
  typedef logic [4:0] ms_time_t;
  typedef logic [9:0] hang_t;

  // Gray coded so one bit changes per step
  typedef enum logic [1:0] {
    IDLE  = 2'b00,
    FREQ1 = 2'b01,
    FREQ2 = 2'b11,
    FREQ3 = 2'b10
  } cmd_state_e;

  typedef enum logic [2:0] {
    NOTX   = 3'b000,
    PRETX  = 3'b001,
    PTTTX  = 3'b011,
    CWTX   = 3'b101,
    CWHANG = 3'b100
  } tx_state_e;

  // ------------------------------------------------------------------------
  // Command word, one view per register address
  // ------------------------------------------------------------------------
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [28:0] rsvd_hi;
      logic        duplex;
      logic [1:0]  rsvd_lo;
    } ctrl;
    struct packed {
      logic [7:0]  rsvd_hi;
      logic        en;
      logic [22:0] rsvd_lo;
    } vna;
    struct packed {
      logic [7:0]  hi;
      logic [5:0]  rsvd_mid;
      logic [1:0]  lo;
      logic [15:0] rsvd_lo;
    } cw_hang;
    struct packed {
      logic [18:0] rsvd_hi;
      logic [4:0]  ptt_hang;
      logic [2:0]  rsvd_mid;
      logic [4:0]  latency;
    } tx_timing;
  } cmd_word_u;

endpackage

`default_nettype wire

/* source/cmd_decoder.sv */
`default_nettype none
`timescale 1ns/100ps
`include "radio_ctrl_config.svh"

module cmd_decoder import radio_ctrl_pkg::*; (
  input  logic       clk,
  input  logic       rst_all,
  input  logic [5:0] cmd_addr_i,
  input  cmd_word_u  cmd_data_i,
  input  logic       cmd_rqst_i,
  output logic       cmd_ack_o,
  output logic       freq_capture_o,
  output logic       freq_commit_o,
  output logic       duplex_o,
  output logic       vna_o,
  output hang_t      cw_hang_o,
  output ms_time_t   latency_o,
  output ms_time_t   ptt_hang_o
);

  cmd_state_e state;
  logic       freq_addr;

  // All frequency slots of the full radio take the 3-cycle path
  assign freq_addr = cmd_addr_i inside {[6'h01:6'h08], [6'h12:6'h16]};

  always_ff @(posedge clk) begin
    if (rst_all) begin
      state      <= IDLE;
      duplex_o   <= 1'b0;
      vna_o      <= 1'b0;
      cw_hang_o  <= '0;
      latency_o  <= `RC_LATENCY_RST;
      ptt_hang_o <= `RC_PTT_HANG_RST;
    end else begin
      case (state)
        IDLE: begin
          // Requests outside IDLE are dropped
          if (cmd_rqst_i) begin
            if (freq_addr) state <= FREQ1;
            case (cmd_addr_i)
              `RC_ADDR_CTRL: duplex_o <= cmd_data_i.ctrl.duplex;
              `RC_ADDR_VNA:  vna_o    <= cmd_data_i.vna.en;
              `RC_ADDR_CW_HANG: begin
                cw_hang_o <= {cmd_data_i.cw_hang.hi, cmd_data_i.cw_hang.lo};
              end
              `RC_ADDR_TX_TIMING: begin
                latency_o  <= cmd_data_i.tx_timing.latency;
                ptt_hang_o <= cmd_data_i.tx_timing.ptt_hang;
              end
              // Predistortion select has no target here
              `RC_ADDR_PRED: ;
              default: ;
            endcase
          end
        end
        // Two cycles for the multiplier
        FREQ1: state <= FREQ2;
        FREQ2: state <= FREQ3;
        FREQ3: state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // Product sampled in FREQ2 and phases written in FREQ3
  assign freq_capture_o = (state == FREQ2);
  assign freq_commit_o  = (state == FREQ3);
  // Ack only for frequency commands
  assign cmd_ack_o      = (state == FREQ3);

endmodule

`default_nettype wire

/* source/freq_phase_calc.sv */
`default_nettype none
`timescale 1ns/100ps
`include "radio_ctrl_config.svh"

module freq_phase_calc import radio_ctrl_pkg::*; (
  input  logic        clk,
  input  logic        rst_all,
  input  logic [5:0]  cmd_addr_i,
  input  logic [31:0] cmd_data_i,
  input  logic        freq_capture_i,
  input  logic        freq_commit_i,
  input  logic        duplex_i,
  output phase_t      tx_phase_o,
  output phase_t      rx_phase_o
);

  logic [63:0] freq_prod;
  phase_t      freq_q;
  logic [5:0]  chan_q;

  // Rounded product of the Hz word and 2^57/clk holds the phase step on top
  assign freq_prod = 64'(cmd_data_i) * 64'(`RC_PHASE_MULT) + 64'(`RC_PHASE_ROUND);

  // Multiplier result has settled by FREQ2
  always_ff @(posedge clk) begin
    if (freq_capture_i) begin
      freq_q <= freq_prod[`RC_PHASE_MSB:`RC_PHASE_LSB];
      chan_q <= cmd_addr_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_all) begin
      tx_phase_o <= '0;
      rx_phase_o <= '0;
    end else if (freq_commit_i) begin
      if (chan_q == `RC_FREQ_ADDR_TX0) begin
        tx_phase_o <= freq_q;
        // Simplex RX follows TX
        if (!duplex_i) rx_phase_o <= freq_q;
      end
      if (chan_q == `RC_FREQ_ADDR_RX0) begin
        // Simplex keeps RX on the TX frequency
        rx_phase_o <= duplex_i ? freq_q : tx_phase_o;
      end
    end
  end

endmodule

`default_nettype wire

/* source/tx_keying_fsm.sv */
`default_nettype none
`timescale 1ns/100ps

module tx_keying_fsm import radio_ctrl_pkg::*; (
  input  logic       clk,
  input  logic       rst_all,
  input  logic       run_i,
  input  logic       ext_keydown_i,
  input  logic       qmsec_pulse_i,
  input  logic       tx_tvalid_i,
  input  logic [3:0] tx_tuser_i,
  input  logic       sample_req_i,
  input  ms_time_t   latency_i,
  input  ms_time_t   ptt_hang_i,
  input  logic       timer_zero_i,
  input  logic       level_zero_i,
  input  logic       level_max_i,
  input  logic       backlog_nonzero_i,
  output logic       tx_on_o,
  output logic       cw_on_o,
  output logic       tx_tready_o,
  output logic       cw_key_o,
  output logic       timer_load_o,
  output qtimer_t    timer_value_o,
  output logic       timer_dec_o,
  output logic       level_up_o,
  output logic       level_down_o,
  output logic       level_hang_load_o,
  output logic       level_clear_o,
  output logic       sample_latch_o,
  output logic       sample_clear_o,
  output logic       backlog_incr_o,
  output logic       backlog_decr_o
);

  tx_state_e state;
  tx_state_e state_next;
  logic      cwx;
  logic      ptt;
  logic      cw_req;
  logic      key_any;

  // Keying requests ride on the sample stream sideband
  assign cwx     = tx_tuser_i[2] & tx_tvalid_i;
  assign ptt     = tx_tuser_i[3] & tx_tvalid_i;
  assign cw_req  = ext_keydown_i | cwx;
  assign key_any = cw_req | ptt;

  // Dropping run parks the transmitter at once
  always_ff @(posedge clk) begin
    if (rst_all || !run_i) state <= NOTX;
    else                   state <= state_next;
  end

  always_comb begin
    state_next        = state;
    tx_on_o           = 1'b1;
    cw_on_o           = 1'b0;
    cw_key_o          = 1'b0;
    tx_tready_o       = sample_req_i;
    timer_load_o      = 1'b0;
    timer_value_o     = {latency_i, 2'b00};
    timer_dec_o       = 1'b0;
    level_up_o        = 1'b0;
    level_down_o      = 1'b0;
    level_hang_load_o = 1'b0;
    level_clear_o     = 1'b0;
    sample_latch_o    = 1'b0;
    sample_clear_o    = 1'b0;
    backlog_incr_o    = 1'b0;
    backlog_decr_o    = 1'b0;

    case (state)
      NOTX: begin
        tx_on_o        = 1'b0;
        sample_clear_o = 1'b1;
        level_clear_o  = 1'b1;
        timer_load_o   = 1'b1;
        // Drain samples banked in PRETX so host time stays coherent
        backlog_decr_o = ~sample_req_i;
        tx_tready_o    = backlog_nonzero_i | sample_req_i;
        if (key_any) state_next = PRETX;
      end

      PRETX: begin
        // Stall the stream so the host buffer fills for the latency time
        tx_tready_o    = 1'b0;
        backlog_incr_o = sample_req_i;
        if (!timer_zero_i) begin
          timer_dec_o = 1'b1;
          if (!key_any) state_next = NOTX;
        end else if (cw_req) begin
          state_next = CWTX;
        end else begin
          state_next = PTTTX;
        end
      end

      PTTTX: begin
        if (ext_keydown_i) begin
          state_next = CWTX;
        end else if (ptt) begin
          // Hang restarts while PTT is held
          timer_load_o   = 1'b1;
          timer_value_o  = {ptt_hang_i, 2'b00};
          sample_latch_o = sample_req_i;
        end else if (!timer_zero_i) begin
          timer_dec_o = 1'b1;
        end else begin
          state_next = NOTX;
        end
      end

      CWTX: begin
        cw_on_o  = 1'b1;
        cw_key_o = 1'b1;
        if (cw_req) begin
          // Rising edge of the keying envelope
          level_up_o   = ~level_max_i;
          timer_load_o = 1'b1;
        end else if (!timer_zero_i) begin
          // Key up delayed by the buffer latency
          timer_dec_o = 1'b1;
        end else if (!level_zero_i) begin
          level_down_o = 1'b1;
        end else begin
          // Level register reused as the hang counter
          timer_load_o      = 1'b1;
          level_hang_load_o = 1'b1;
          state_next        = CWHANG;
        end
      end

      CWHANG: begin
        cw_on_o = 1'b1;
        if (cw_req) begin
          if (!timer_zero_i) begin
            timer_dec_o = 1'b1;
          end else begin
            timer_load_o  = 1'b1;
            level_clear_o = 1'b1;
            state_next    = CWTX;
          end
        end else if (!level_zero_i) begin
          // Hang counts down in quarter ms
          level_down_o = qmsec_pulse_i;
        end else begin
          state_next = NOTX;
        end
      end

      default: state_next = NOTX;
    endcase
  end

endmodule

`default_nettype wire

/* source/qmsec_timer.sv */
`default_nettype none
`timescale 1ns/100ps

module qmsec_timer import radio_ctrl_pkg::*; (
  input  logic    clk,
  input  logic    rst_all,
  input  logic    load_i,
  input  qtimer_t value_i,
  input  logic    dec_i,
  input  logic    qmsec_pulse_i,
  output logic    zero_o
);

  qtimer_t count;

  // Load wins over count down
  always_ff @(posedge clk) begin
    if (rst_all) begin
      count <= '0;
    end else if (load_i) begin
      count <= value_i;
    end else if (dec_i && qmsec_pulse_i && !zero_o) begin
      count <= count - qtimer_t'(1);
    end
  end

  assign zero_o = (count == '0);

endmodule

`default_nettype wire

/* source/cw_level_shaper.sv */
`default_nettype none
`timescale 1ns/100ps
`include "radio_ctrl_config.svh"

module cw_level_shaper import radio_ctrl_pkg::*; (
  input  logic      clk,
  input  logic      rst_all,
  input  logic      up_i,
  input  logic      down_i,
  input  logic      hang_load_i,
  input  hang_t     hang_i,
  input  logic      clear_i,
  output cw_level_t level_o,
  output logic      zero_o,
  output logic      max_o
);

  // One LSB per step with the top 15 bits driving I
  always_ff @(posedge clk) begin
    if (rst_all || clear_i) begin
      level_o <= '0;
    end else if (hang_load_i) begin
      // Hang time in quarter ms
      level_o <= {7'b0000000, hang_i, 2'b00};
    end else if (up_i && !max_o) begin
      level_o <= level_o + cw_level_t'(1);
    end else if (down_i && !zero_o) begin
      level_o <= level_o - cw_level_t'(1);
    end
  end

  assign zero_o = (level_o == '0);
  assign max_o  = (level_o == `RC_MAX_CWLEVEL);

endmodule

`default_nettype wire

/* source/tx_baseband_mux.sv */
`default_nettype none
`timescale 1ns/100ps
`include "radio_ctrl_config.svh"

module tx_baseband_mux import radio_ctrl_pkg::*; (
  input  logic        clk,
  input  logic        rst_all,
  input  logic [31:0] tx_tdata_i,
  input  logic        latch_i,
  input  logic        clear_i,
  input  logic        incr_i,
  input  logic        decr_i,
  input  logic        vna_i,
  input  logic        cw_key_i,
  input  cw_level_t   level_i,
  output logic        backlog_nonzero_o,
  output iq_sample_t  tx_i_o,
  output iq_sample_t  tx_q_o
);

  iq_sample_t  ptt_i;
  iq_sample_t  ptt_q;
  logic [10:0] backlog;

  // ------------------------------------------------------------------------
  // PTT sample hold
  // ------------------------------------------------------------------------
  // Held between requests
  always_ff @(posedge clk) begin
    if (clear_i) begin
      ptt_i <= '0;
      ptt_q <= '0;
    end else if (latch_i) begin
      ptt_i <= tx_tdata_i[31:16];
      ptt_q <= tx_tdata_i[15:0];
    end
  end

  // Samples banked during PRETX
  always_ff @(posedge clk) begin
    if (rst_all) begin
      backlog <= '0;
    end else if (incr_i) begin
      backlog <= backlog + 11'd1;
    end else if (decr_i && backlog_nonzero_o) begin
      backlog <= backlog - 11'd1;
    end
  end

  assign backlog_nonzero_o = |backlog;

  // ------------------------------------------------------------------------
  // Output select with VNA over CW over voice
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst_all) begin
      tx_i_o <= '0;
      tx_q_o <= '0;
    end else if (vna_i) begin
      tx_i_o <= `RC_VNA_DRIVE;
      tx_q_o <= '0;
    end else if (cw_key_i) begin
      // Carrier on I only
      tx_i_o <= {1'b0, level_i[18:4]};
      tx_q_o <= '0;
    end else begin
      tx_i_o <= ptt_i;
      tx_q_o <= ptt_q;
    end
  end

endmodule

`default_nettype wire

/* source/radio_ctrl_top.sv */
`default_nettype none
`timescale 1ns/100ps

module radio_ctrl_top import radio_ctrl_pkg::*; (
  input  logic        clk,
  input  logic        rst_all,
  input  logic        run_i,
  input  logic        qmsec_pulse_i,
  input  logic        ext_keydown_i,
  input  logic [31:0] tx_tdata_i,
  input  logic        tx_tvalid_i,
  input  logic [3:0]  tx_tuser_i,
  input  logic        sample_req_i,
  input  logic [5:0]  cmd_addr_i,
  input  cmd_word_u   cmd_data_i,
  input  logic        cmd_rqst_i,
  output logic        tx_tready_o,
  output logic        tx_on_o,
  output logic        cw_on_o,
  output iq_sample_t  tx_i_o,
  output iq_sample_t  tx_q_o,
  output phase_t      tx_phase_o,
  output phase_t      rx_phase_o,
  output logic        cmd_ack_o
);

  logic      freq_capture, freq_commit;
  logic      duplex, vna;
  hang_t     cw_hang;
  ms_time_t  latency, ptt_hang;
  logic      cw_key;
  logic      timer_load, timer_dec, timer_zero;
  qtimer_t   timer_value;
  logic      level_up, level_down, level_hang_load, level_clear;
  logic      level_zero, level_max;
  cw_level_t level;
  logic      sample_latch, sample_clear;
  logic      backlog_incr, backlog_decr, backlog_nonzero;

  // ------------------------------------------------------------------------
  // Command side
  // ------------------------------------------------------------------------
  cmd_decoder u_cmd (
    .clk, .rst_all, .cmd_addr_i, .cmd_data_i, .cmd_rqst_i, .cmd_ack_o,
    .freq_capture_o(freq_capture), .freq_commit_o(freq_commit),
    .duplex_o(duplex), .vna_o(vna), .cw_hang_o(cw_hang),
    .latency_o(latency), .ptt_hang_o(ptt_hang)
  );

  freq_phase_calc u_freq (
    .clk, .rst_all, .cmd_addr_i, .cmd_data_i(cmd_data_i.raw),
    .freq_capture_i(freq_capture), .freq_commit_i(freq_commit),
    .duplex_i(duplex), .tx_phase_o, .rx_phase_o
  );

  // ------------------------------------------------------------------------
  // Transmit keying
  // ------------------------------------------------------------------------
  tx_keying_fsm u_keying (
    .clk, .rst_all, .run_i, .ext_keydown_i, .qmsec_pulse_i,
    .tx_tvalid_i, .tx_tuser_i, .sample_req_i,
    .latency_i(latency), .ptt_hang_i(ptt_hang), .timer_zero_i(timer_zero),
    .level_zero_i(level_zero), .level_max_i(level_max),
    .backlog_nonzero_i(backlog_nonzero),
    .tx_on_o, .cw_on_o, .tx_tready_o, .cw_key_o(cw_key),
    .timer_load_o(timer_load), .timer_value_o(timer_value), .timer_dec_o(timer_dec),
    .level_up_o(level_up), .level_down_o(level_down),
    .level_hang_load_o(level_hang_load), .level_clear_o(level_clear),
    .sample_latch_o(sample_latch), .sample_clear_o(sample_clear),
    .backlog_incr_o(backlog_incr), .backlog_decr_o(backlog_decr)
  );

  qmsec_timer u_timer (
    .clk, .rst_all, .load_i(timer_load), .value_i(timer_value),
    .dec_i(timer_dec), .qmsec_pulse_i, .zero_o(timer_zero)
  );

  cw_level_shaper u_level (
    .clk, .rst_all, .up_i(level_up), .down_i(level_down),
    .hang_load_i(level_hang_load), .hang_i(cw_hang), .clear_i(level_clear),
    .level_o(level), .zero_o(level_zero), .max_o(level_max)
  );

  // Baseband toward the external interpolator
  tx_baseband_mux u_mux (
    .clk, .rst_all, .tx_tdata_i, .latch_i(sample_latch), .clear_i(sample_clear),
    .incr_i(backlog_incr), .decr_i(backlog_decr), .vna_i(vna),
    .cw_key_i(cw_key), .level_i(level),
    .backlog_nonzero_o(backlog_nonzero), .tx_i_o, .tx_q_o
  );

endmodule

`default_nettype wire

/* dv/radio_ctrl_assert.sv */
`default_nettype none
`timescale 1ns/100ps

module radio_ctrl_assert import radio_ctrl_pkg::*; (
  input wire logic      clk,
  input wire logic      rst_all,
  input wire logic      cmd_ack_o,
  input wire logic      cw_on_o,
  input wire logic      tx_on_o,
  input wire logic      tx_tready_o,
  input wire tx_state_e tx_state
);

  // Ack is a single cycle pulse
  ack_pulse: assert property (@(posedge clk) disable iff (rst_all)
    cmd_ack_o |=> !cmd_ack_o)
    else $error("cmd_ack_o held for more than one cycle");

  // CW keying is a transmit state
  cw_in_tx: assert property (@(posedge clk) disable iff (rst_all)
    cw_on_o |-> tx_on_o)
    else $error("cw_on_o high while tx_on_o low");

  // Host stream stalled while the buffer fills
  pretx_stall: assert property (@(posedge clk) disable iff (rst_all)
    (tx_state == PRETX) |-> !tx_tready_o)
    else $error("tx_tready_o high in PRETX");

endmodule

bind radio_ctrl_top radio_ctrl_assert u_assert (
  .clk, .rst_all, .cmd_ack_o, .cw_on_o, .tx_on_o, .tx_tready_o,
  .tx_state(u_keying.state)
);

`default_nettype wire

/* dv/radio_ctrl_tb.sv */
`default_nettype none
`timescale 1ns/100ps

module radio_ctrl_tb import radio_ctrl_pkg::*; ();

  localparam longint unsigned CLK_HZ = 76800000;
  // Rounded 2^57 / clock
  localparam longint unsigned MULT = ((64'd1 << 57) + CLK_HZ / 2) / CLK_HZ;
  localparam cw_level_t  MAX_LEVEL = 19'h4d800;
  localparam iq_sample_t VNA_I = 16'sh4d80;
  localparam int LIMIT = 4 * (400 + 1500 + 2 * 317440 + 2000 + 500 + 2000);

  logic clk, rst_all, run_i, qmsec_pulse_i, ext_keydown_i;
  logic tx_tvalid_i, sample_req_i, cmd_rqst_i;
  logic [31:0] tx_tdata_i;
  logic [3:0]  tx_tuser_i;
  logic [5:0]  cmd_addr_i;
  cmd_word_u   cmd_data_i;
  logic tx_tready_o, tx_on_o, cw_on_o, cmd_ack_o;
  iq_sample_t tx_i_o, tx_q_o;
  phase_t tx_phase_o, rx_phase_o;

  // Reference model state
  tx_state_e  m_state;
  qtimer_t    m_timer;
  cw_level_t  m_level;
  iq_sample_t m_lat_i, m_lat_q, m_out_i, m_out_q;
  logic [10:0] m_backlog;
  logic       m_duplex, m_vna;
  hang_t      m_cw_hang;
  ms_time_t   m_latency, m_ptt_hang;
  int         m_cstate;
  phase_t     m_cap, m_tx_phase, m_rx_phase;
  logic [5:0] m_chan;

  logic obs_ack, obs_tready, obs_on, obs_cw;
  iq_sample_t obs_i;
  logic [31:0] rng;
  int err_count;
  int tick_count;

  radio_ctrl_top DUT (.*);

  always #50 clk = ~clk;

  // Timeout guard
  always @(posedge clk) begin
    tick_count <= tick_count + 1;
    if (tick_count >= LIMIT) begin
      $display("Timeout after %0d cycles, the DUT stopped responding", tick_count);
      $display("Simulation failed");
      $fatal(1, "timeout");
    end
  end

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng = x;
    return x;
  endfunction

  // Hz word to phase step by rounding and slicing 56:25
  function automatic phase_t expected_phase(input logic [31:0] hz);
    logic [63:0] prod;
    prod = {32'd0, hz} * MULT + 64'd16777216;
    return prod[56:25];
  endfunction

  // --------------------------------------------------------------------------
  // Compare tasks
  // --------------------------------------------------------------------------
  task automatic stop_on_error();
    err_count = err_count + 1;
    $display("Simulation failed");
    $fatal(1, "first error reached");
  endtask

  task automatic check_phase(input string name, input phase_t got, input phase_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_iq(input string name, input iq_sample_t got, input iq_sample_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic model_reset();
    m_state = NOTX;
    m_timer = '0;
    m_level = '0;
    m_lat_i = '0;
    m_lat_q = '0;
    m_out_i = '0;
    m_out_q = '0;
    m_backlog = '0;
    m_duplex = 1'b0;
    m_vna = 1'b0;
    m_cw_hang = '0;
    m_latency = 5'd10;
    m_ptt_hang = 5'd4;
    m_cstate = 0;
    m_tx_phase = '0;
    m_rx_phase = '0;
  endtask

  task automatic compare_outputs();
    logic exp_ready;
    if (m_state == NOTX) exp_ready = (m_backlog != 0) | sample_req_i;
    else if (m_state == PRETX) exp_ready = 1'b0;
    else exp_ready = sample_req_i;
    check_flag("tx_on_o", tx_on_o, m_state != NOTX);
    check_flag("cw_on_o", cw_on_o, (m_state == CWTX) || (m_state == CWHANG));
    check_flag("tx_tready_o", tx_tready_o, exp_ready);
    check_flag("cmd_ack_o", cmd_ack_o, m_cstate == 3);
    check_iq("tx_i_o", tx_i_o, m_out_i);
    check_iq("tx_q_o", tx_q_o, m_out_q);
    check_phase("tx_phase_o", tx_phase_o, m_tx_phase);
    check_phase("rx_phase_o", rx_phase_o, m_rx_phase);
  endtask

  // --------------------------------------------------------------------------
  // Model step at the rising edge on pre-edge values
  // --------------------------------------------------------------------------
  task automatic model_update();
    logic cwr, ptt, key_any, req, pls;
    tx_state_e nxt;
    ptt = tx_tvalid_i & tx_tuser_i[3];
    cwr = ext_keydown_i | (tx_tvalid_i & tx_tuser_i[2]);
    key_any = cwr | ptt;
    req = sample_req_i;
    pls = qmsec_pulse_i;
    nxt = m_state;
    // Output register with VNA over CW over voice
    if (m_vna) begin
      m_out_i = VNA_I;
      m_out_q = '0;
    end else if (m_state == CWTX) begin
      m_out_i = {1'b0, m_level[18:4]};
      m_out_q = '0;
    end else begin
      m_out_i = m_lat_i;
      m_out_q = m_lat_q;
    end
    case (m_state)
      NOTX: begin
        m_lat_i = '0;
        m_lat_q = '0;
        m_level = '0;
        m_timer = {m_latency, 2'b00};
        if (!req && m_backlog != 0) m_backlog = m_backlog - 11'd1;
        if (key_any) nxt = PRETX;
      end
      PRETX: begin
        if (req) m_backlog = m_backlog + 11'd1;
        if (m_timer != 0) begin
          if (!key_any) nxt = NOTX;
          if (pls) m_timer = m_timer - 7'd1;
        end else begin
          nxt = cwr ? CWTX : PTTTX;
        end
      end
      PTTTX: begin
        if (ext_keydown_i) begin
          nxt = CWTX;
        end else if (ptt) begin
          m_timer = {m_ptt_hang, 2'b00};
          if (req) begin
            m_lat_i = tx_tdata_i[31:16];
            m_lat_q = tx_tdata_i[15:0];
          end
        end else if (m_timer != 0) begin
          if (pls) m_timer = m_timer - 7'd1;
        end else begin
          nxt = NOTX;
        end
      end
      CWTX: begin
        if (cwr) begin
          if (m_level != MAX_LEVEL) m_level = m_level + 19'd1;
          m_timer = {m_latency, 2'b00};
        end else if (m_timer != 0) begin
          if (pls) m_timer = m_timer - 7'd1;
        end else if (m_level != 0) begin
          m_level = m_level - 19'd1;
        end else begin
          // Hang count in quarter ms
          m_timer = {m_latency, 2'b00};
          m_level = {7'd0, m_cw_hang, 2'b00};
          nxt = CWHANG;
        end
      end
      CWHANG: begin
        if (cwr) begin
          if (m_timer != 0) begin
            if (pls) m_timer = m_timer - 7'd1;
          end else begin
            m_timer = {m_latency, 2'b00};
            m_level = '0;
            nxt = CWTX;
          end
        end else if (m_level != 0) begin
          if (pls) m_level = m_level - 19'd1;
        end else begin
          nxt = NOTX;
        end
      end
      default: nxt = NOTX;
    endcase
    m_state = run_i ? nxt : NOTX;
    // Command slave
    case (m_cstate)
      0: begin
        if (cmd_rqst_i) begin
          if ((cmd_addr_i >= 6'h01 && cmd_addr_i <= 6'h08) ||
              (cmd_addr_i >= 6'h12 && cmd_addr_i <= 6'h16)) m_cstate = 1;
          case (cmd_addr_i)
            6'h00: m_duplex = cmd_data_i.raw[2];
            6'h09: m_vna = cmd_data_i.raw[23];
            6'h10: m_cw_hang = {cmd_data_i.raw[31:24], cmd_data_i.raw[17:16]};
            6'h17: begin
              m_latency = cmd_data_i.raw[4:0];
              m_ptt_hang = cmd_data_i.raw[12:8];
            end
            default: ;
          endcase
        end
      end
      1: m_cstate = 2;
      2: begin
        m_cap = expected_phase(cmd_data_i.raw);
        m_chan = cmd_addr_i;
        m_cstate = 3;
      end
      default: begin
        if (m_chan == 6'h01) begin
          m_tx_phase = m_cap;
          if (!m_duplex) m_rx_phase = m_cap;
        end else if (m_chan == 6'h02) begin
          m_rx_phase = m_duplex ? m_cap : m_tx_phase;
        end
        m_cstate = 0;
      end
    endcase
  endtask

  // One clock of checking at the falling edge and stepping the model before new inputs
  task automatic run_cycle();
    logic [31:0] r;
    @(negedge clk);
    compare_outputs();
    obs_ack = cmd_ack_o;
    obs_tready = tx_tready_o;
    obs_on = tx_on_o;
    obs_cw = cw_on_o;
    obs_i = tx_i_o;
    @(posedge clk);
    model_update();
    #1;
    r = next_rand();
    qmsec_pulse_i = (r[1:0] == 2'b00);
    sample_req_i = r[4];
    tx_tdata_i = next_rand();
  endtask

  task automatic run_cycles(input int n);
    repeat (n) run_cycle();
  endtask

  task automatic write_reg(input logic [5:0] addr, input logic [31:0] data);
    cmd_addr_i = addr;
    cmd_data_i.raw = data;
    cmd_rqst_i = 1'b1;
    run_cycle();
    cmd_rqst_i = 1'b0;
    repeat (3) begin
      run_cycle();
      check_flag("cmd_ack_o", obs_ack, 1'b0);
    end
  endtask

  task automatic freq_cmd(input logic [5:0] addr, input logic [31:0] hz,
                          input logic again);
    int n;
    cmd_addr_i = addr;
    cmd_data_i.raw = hz;
    cmd_rqst_i = 1'b1;
    run_cycle();
    // A strobe held while busy must not restart the command
    cmd_rqst_i = again;
    n = 0;
    do begin
      run_cycle();
      n = n + 1;
    end while (!obs_ack && n < 8);
    cmd_rqst_i = 1'b0;
    if (n != 3) begin
      $display("Frequency command acknowledged after %0d cycles instead of 3", n);
      stop_on_error();
    end
    // Phases land on the edge that ends the ack
    run_cycle();
  endtask

  // Bounded wait for a DUT flag to reach a level
  task automatic wait_on(input int which, input logic level, input int bound);
    int n;
    n = 0;
    while (n < bound) begin
      run_cycle();
      n = n + 1;
      if (which == 0 && obs_on == level) break;
      if (which == 1 && obs_cw == level) break;
      if (which == 2 && obs_tready == level && obs_on) break;
      if (which == 3 && obs_i == VNA_I) break;
    end
    if (n >= bound) begin
      $display("Transmit keying did not reach the expected state in %0d cycles", bound);
      stop_on_error();
    end
  endtask

  initial begin
    logic [31:0] d;
    clk = 1'b0;
    rst_all = 1'b1;
    run_i = 1'b1;
    qmsec_pulse_i = 1'b0;
    ext_keydown_i = 1'b0;
    tx_tdata_i = '0;
    tx_tvalid_i = 1'b0;
    tx_tuser_i = '0;
    sample_req_i = 1'b0;
    cmd_addr_i = '0;
    cmd_data_i.raw = '0;
    cmd_rqst_i = 1'b0;
    rng = 32'hefba76d0;
    err_count = 0;
    tick_count = 0;
    repeat (3) @(posedge clk);
    #1;
    rst_all = 1'b0;
    model_reset();

    // Frequency commands with random duplex
    repeat (24) begin
      d = next_rand();
      if (d[0]) write_reg(6'h00, next_rand());
      freq_cmd(d[9] ? 6'h02 : 6'h01, next_rand(), d[5]);
    end

    // Short timings keep the keying runs brief
    d = next_rand();
    d[4:0] = 5'd1 + {3'd0, d[21:20]};
    d[12:8] = 5'd1 + {3'd0, d[23:22]};
    write_reg(6'h17, d);
    d = next_rand();
    d[31:25] = '0;
    write_reg(6'h10, d);
    write_reg(6'h2b, next_rand());

    // PTT keying
    tx_tvalid_i = 1'b1;
    tx_tuser_i = 4'b1000;
    wait_on(2, 1'b1, 500);
    run_cycles(60);
    tx_tvalid_i = 1'b0;
    wait_on(0, 1'b0, 500);
    run_cycles(10);

    // CW ramp to full drive and back through hang
    ext_keydown_i = 1'b1;
    wait_on(1, 1'b1, 500);
    wait_on(3, 1'b1, 320000);
    run_cycles(20);
    ext_keydown_i = 1'b0;
    wait_on(1, 1'b0, 330000);
    run_cycles(10);

    // VNA drive overrides the sample stream
    write_reg(6'h09, 32'h0080_0000);
    tx_tvalid_i = 1'b1;
    tx_tuser_i = 4'b1000;
    run_cycles(80);
    tx_tvalid_i = 1'b0;
    write_reg(6'h09, 32'h0);
    wait_on(0, 1'b0, 500);

    // Run low drops keying from CW
    tx_tvalid_i = 1'b1;
    tx_tuser_i = 4'b0100;
    wait_on(1, 1'b1, 500);
    run_cycles(20);
    run_i = 1'b0;
    run_cycles(2);
    check_flag("tx_on_o", obs_on, 1'b0);
    check_flag("cw_on_o", obs_cw, 1'b0);
    tx_tvalid_i = 1'b0;
    run_i = 1'b1;
    run_cycles(20);

    if (err_count == 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      $display("Simulation failed");
      $fatal(1, "checks failed");
    end
  end

endmodule

`default_nettype wire

/* radio_ctrl.f */
+incdir+source
source/radio_ctrl_pkg.sv
source/cmd_decoder.sv
source/freq_phase_calc.sv
source/tx_keying_fsm.sv
source/qmsec_timer.sv
source/cw_level_shaper.sv
source/tx_baseband_mux.sv
source/radio_ctrl_top.sv
dv/radio_ctrl_assert.sv
dv/radio_ctrl_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= radio_ctrl_tb
DUT_TOP   ?= radio_ctrl_top
FLIST     ?= radio_ctrl.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --assert --timing
PASS_MSG  ?= Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
